//--- async_fifo.f
+incdir+logic
logic/fifo_pkg.sv
logic/ram_tp.sv
logic/gray_sync.sv
logic/fifo_wr_ctrl.sv
logic/fifo_rd_ctrl.sv
logic/async_fifo_top.sv
testbench/tb_async_fifo.sv

//--- logic/async_fifo_top.sv
// async_fifo_top: 32-bit write, 8-bit read asynchronous FIFO
// controllers, pointer synchronizers and storage RAM
`include "fifo_cfg.svh"

module async_fifo_top (
    input  logic               wr_clk_i,
    input  logic               rd_clk_i,
    input  logic               rst_n_i,

    input  logic               wr_en_i,
    input  fifo_pkg::wr_word_t wr_data_i,
    output logic               wr_full_o,

    input  logic               rd_en_i,
    output fifo_pkg::rd_byte_t rd_data_o,
    output logic               rd_valid_o,
    output logic               rd_empty_o
);

import fifo_pkg::*;

wr_ptr_t  wr_ptr;
wr_ptr_t  wr_ptr_sync;
rd_ptr_t  rd_ptr;
rd_ptr_t  rd_ptr_sync;

logic                              ram_wr_en;
logic [$clog2(`FIFO_WR_DEPTH)-1:0] ram_wr_addr;
wr_word_t                          ram_wr_data;
logic                              ram_rd_en;
logic [$clog2(`FIFO_RD_DEPTH)-1:0] ram_rd_addr;

fifo_wr_ctrl u_wr_ctrl (
    .wr_clk_i      (wr_clk_i),
    .rst_n_i       (rst_n_i),
    .wr_en_i       (wr_en_i),
    .wr_data_i     (wr_data_i),
    .rd_ptr_sync_i (rd_ptr_sync),
    .wr_full_o     (wr_full_o),
    .ram_wr_en_o   (ram_wr_en),
    .ram_wr_addr_o (ram_wr_addr),
    .ram_wr_data_o (ram_wr_data),
    .wr_ptr_o      (wr_ptr)
);

fifo_rd_ctrl u_rd_ctrl (
    .rd_clk_i      (rd_clk_i),
    .rst_n_i       (rst_n_i),
    .rd_en_i       (rd_en_i),
    .wr_ptr_sync_i (wr_ptr_sync),
    .rd_empty_o    (rd_empty_o),
    .rd_valid_o    (rd_valid_o),
    .ram_rd_en_o   (ram_rd_en),
    .ram_rd_addr_o (ram_rd_addr),
    .rd_ptr_o      (rd_ptr)
);

// word pointer into the read domain
gray_sync #(
    .WIDTH ($bits(wr_ptr_t))
) u_wr_ptr_sync (
    .src_clk_i (wr_clk_i),
    .dst_clk_i (rd_clk_i),
    .rst_n_i   (rst_n_i),
    .src_bin_i (wr_ptr),
    .dst_bin_o (wr_ptr_sync)
);

// byte pointer into the write domain
gray_sync #(
    .WIDTH ($bits(rd_ptr_t))
) u_rd_ptr_sync (
    .src_clk_i (rd_clk_i),
    .dst_clk_i (wr_clk_i),
    .rst_n_i   (rst_n_i),
    .src_bin_i (rd_ptr),
    .dst_bin_o (rd_ptr_sync)
);

ram_tp #(
    .I_WIDTH (`FIFO_WR_WIDTH),
    .I_DEPTH (`FIFO_WR_DEPTH),
    .O_WIDTH (`FIFO_RD_WIDTH),
    .O_DEPTH (`FIFO_RD_DEPTH)
) u_ram (
    .wr_clk_i  (wr_clk_i),
    .wr_en_i   (ram_wr_en),
    .wr_addr_i (ram_wr_addr),
    .wr_data_i (ram_wr_data),
    .rd_clk_i  (rd_clk_i),
    .rd_en_i   (ram_rd_en),
    .rd_addr_i (ram_rd_addr),
    .rd_data_o (rd_data_o)
);

endmodule

//--- logic/fifo_cfg.svh
// size macros of the async width-converting FIFO
// word side, byte side and derived byte depth
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// width of one pushed word
`define FIFO_WR_WIDTH 32

// width of one popped byte
`define FIFO_RD_WIDTH 8

// capacity in words, power of two
`define FIFO_WR_DEPTH 16

// capacity in bytes, same storage seen at read width
`define FIFO_RD_DEPTH (`FIFO_WR_DEPTH * `FIFO_WR_WIDTH / `FIFO_RD_WIDTH)

`endif

//--- logic/fifo_pkg.sv
// fifo_pkg: data and pointer vector types of the async FIFO
`include "fifo_cfg.svh"

package fifo_pkg;

    // one pushed word
    typedef logic [`FIFO_WR_WIDTH-1:0] wr_word_t;

    // one popped byte
    typedef logic [`FIFO_RD_WIDTH-1:0] rd_byte_t;

    // word pointer, msb is the wrap bit
    typedef logic [$clog2(`FIFO_WR_DEPTH):0] wr_ptr_t;

    // byte pointer, msb is the wrap bit
    typedef logic [$clog2(`FIFO_RD_DEPTH):0] rd_ptr_t;

endpackage

//--- logic/fifo_rd_ctrl.sv
// fifo_rd_ctrl: byte read pointer, RAM read strobe,
// empty flag and output valid
`include "fifo_cfg.svh"

module fifo_rd_ctrl (
    input  logic                               rd_clk_i,
    input  logic                               rst_n_i,
    input  logic                               rd_en_i,
    input  fifo_pkg::wr_ptr_t                  wr_ptr_sync_i,
    output logic                               rd_empty_o,
    output logic                               rd_valid_o,
    output logic                               ram_rd_en_o,
    output logic [$clog2(`FIFO_RD_DEPTH)-1:0]  ram_rd_addr_o,
    output fifo_pkg::rd_ptr_t                  rd_ptr_o
);

import fifo_pkg::*;

// number of byte lanes per word, as address bits
localparam int LANE_BITS = $bits(rd_ptr_t) - $bits(wr_ptr_t);

rd_ptr_t rd_ptr;
rd_ptr_t wr_ptr_bytes;
logic    pop;

// synchronized write pointer scaled to byte units
assign wr_ptr_bytes = rd_ptr_t'(wr_ptr_sync_i) << LANE_BITS;

// empty straight from flops, keeps push-to-data latency short
assign rd_empty_o = (rd_ptr == wr_ptr_bytes);

assign pop = rd_en_i & ~rd_empty_o;

always_ff @(posedge rd_clk_i) begin
    if (!rst_n_i) begin
        rd_ptr     <= '0;
        rd_valid_o <= 1'b0;
    end else begin
        rd_ptr     <= rd_ptr + rd_ptr_t'(pop);
        // RAM output register holds the byte on the cycle after the pop
        rd_valid_o <= pop;
    end
end

assign ram_rd_en_o   = pop;
assign ram_rd_addr_o = rd_ptr[$bits(rd_ptr_t)-2:0];

assign rd_ptr_o = rd_ptr;

endmodule

//--- logic/fifo_wr_ctrl.sv
// fifo_wr_ctrl: write pointer, RAM write strobe and full flag
`include "fifo_cfg.svh"

module fifo_wr_ctrl (
    input  logic                               wr_clk_i,
    input  logic                               rst_n_i,
    input  logic                               wr_en_i,
    input  fifo_pkg::wr_word_t                 wr_data_i,
    input  fifo_pkg::rd_ptr_t                  rd_ptr_sync_i,
    output logic                               wr_full_o,
    output logic                               ram_wr_en_o,
    output logic [$clog2(`FIFO_WR_DEPTH)-1:0]  ram_wr_addr_o,
    output fifo_pkg::wr_word_t                 ram_wr_data_o,
    output fifo_pkg::wr_ptr_t                  wr_ptr_o
);

import fifo_pkg::*;

wr_ptr_t wr_ptr;
wr_ptr_t wr_ptr_next;
wr_ptr_t rd_ptr_word;
wr_ptr_t used_words;
logic    push;

assign push = wr_en_i & ~wr_full_o;

assign wr_ptr_next = wr_ptr + wr_ptr_t'(push);

// read pointer in word units; a partly read word stays occupied
assign rd_ptr_word = rd_ptr_sync_i[$bits(rd_ptr_t)-1 -: $bits(wr_ptr_t)];

// wrap-bit arithmetic, difference equals depth only when full
assign used_words = wr_ptr_next - rd_ptr_word;

always_ff @(posedge wr_clk_i) begin
    if (!rst_n_i) begin
        wr_ptr    <= '0;
        wr_full_o <= 1'b0;
    end else begin
        wr_ptr    <= wr_ptr_next;
        wr_full_o <= (used_words == wr_ptr_t'(`FIFO_WR_DEPTH));
    end
end

assign ram_wr_en_o   = push;
assign ram_wr_addr_o = wr_ptr[$bits(wr_ptr_t)-2:0];
assign ram_wr_data_o = wr_data_i;

assign wr_ptr_o = wr_ptr;

endmodule

//--- logic/gray_sync.sv
// gray_sync: binary pointer crossing via registered Gray code
// and a two-flop synchronizer in the destination clock
module gray_sync #(
    parameter int WIDTH = 4
) (
    input  logic             src_clk_i,
    input  logic             dst_clk_i,
    input  logic             rst_n_i,
    input  logic [WIDTH-1:0] src_bin_i,
    output logic [WIDTH-1:0] dst_bin_o
);

logic [WIDTH-1:0] src_gray;
logic [WIDTH-1:0] sync_meta;
logic [WIDTH-1:0] sync_gray;

// launch from a flop so no combinational glitch crosses
always_ff @(posedge src_clk_i) begin
    if (!rst_n_i) begin
        src_gray <= '0;
    end else begin
        src_gray <= src_bin_i ^ (src_bin_i >> 1);
    end
end

always_ff @(posedge dst_clk_i) begin
    if (!rst_n_i) begin
        sync_meta <= '0;
        sync_gray <= '0;
    end else begin
        sync_meta <= src_gray;
        sync_gray <= sync_meta;
    end
end

// binary bit i is the xor of gray bits i and above
always_comb begin
    for (int i = 0; i < WIDTH; i++) begin
        dst_bin_o[i] = ^(sync_gray >> i);
    end
end

endmodule

//--- logic/ram_tp.sv
// ram_tp: dual-clock RAM with independent write and read widths
// storage kept at the narrower width, registered read
module ram_tp #(
    parameter int I_WIDTH = 8,
    parameter int I_DEPTH = 8,
    parameter int O_WIDTH = 8,
    parameter int O_DEPTH = 8
) (
    input  logic                       wr_clk_i,
    input  logic                       wr_en_i,
    input  logic [$clog2(I_DEPTH)-1:0] wr_addr_i,
    input  logic         [I_WIDTH-1:0] wr_data_i,

    input  logic                       rd_clk_i,
    input  logic                       rd_en_i,
    input  logic [$clog2(O_DEPTH)-1:0] rd_addr_i,
    output logic         [O_WIDTH-1:0] rd_data_o
);

localparam int I_AW = $clog2(I_DEPTH);
localparam int O_AW = $clog2(O_DEPTH);

generate
    if (O_WIDTH >= I_WIDTH) begin : g_wide_rd
        localparam int RATIO = O_WIDTH / I_WIDTH;

        logic [I_WIDTH-1:0] mem [I_DEPTH];

        always_ff @(posedge wr_clk_i) begin
            if (wr_en_i) begin
                mem[wr_addr_i] <= wr_data_i;
            end
        end

        // gather RATIO consecutive narrow entries into one read word
        always_ff @(posedge rd_clk_i) begin
            if (rd_en_i) begin
                for (int k = 0; k < RATIO; k++) begin
                    rd_data_o[k*I_WIDTH +: I_WIDTH] <= mem[I_AW'(rd_addr_i * RATIO + k)];
                end
            end
        end
    end else begin : g_wide_wr
        localparam int RATIO = I_WIDTH / O_WIDTH;

        logic [O_WIDTH-1:0] mem [O_DEPTH];

        // lane k of the word lands at narrow address addr*RATIO+k
        always_ff @(posedge wr_clk_i) begin
            if (wr_en_i) begin
                for (int k = 0; k < RATIO; k++) begin
                    mem[O_AW'(wr_addr_i * RATIO + k)] <= wr_data_i[k*O_WIDTH +: O_WIDTH];
                end
            end
        end

        always_ff @(posedge rd_clk_i) begin
            if (rd_en_i) begin
                rd_data_o <= mem[rd_addr_i];
            end
        end
    end
endgenerate

endmodule

//--- run_sim.sh
#!/bin/sh
# build the async FIFO testbench with Verilator and run it
# the exit status is nonzero unless the pass line appears in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f async_fifo.f \
    --top-module tb_async_fifo -o tb_async_fifo \
    && ./obj_dir/tb_async_fifo | tee /dev/stderr | grep -x "STATUS: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- testbench/tb_async_fifo.sv
// testbench of the async width-converting FIFO
// two clocks, directed and random traffic, byte queue model, assertion checks
`include "fifo_cfg.svh"

module tb_async_fifo;

import fifo_pkg::*;

localparam int CYCLE_LIMIT   = 4000;
localparam int RANDOM_CYCLES = 1000;
localparam int LANES         = `FIFO_WR_WIDTH / `FIFO_RD_WIDTH;
localparam int IDLE_CYCLES   = 6;

logic     rd_clk = 1'b0;
logic     wr_clk = 1'b0;
logic     rst_n;
logic     wr_en;
wr_word_t wr_data;
logic     wr_full;
logic     rd_en;
rd_byte_t rd_data;
logic     rd_valid;
logic     rd_empty;

// bytes accepted by the FIFO and not yet seen on the output
rd_byte_t model_q [$];

string test_name = "reset";
int    wr_errors;
int    rd_errors;
int    seq_errors;
int    push_count;
int    pop_count;
int    rx_count;
int    cycle_count;
int    pop_hist [5];
logic  pop_prev;
logic  random_done;
int    rx_start;
int    push_start;

always #10 rd_clk = ~rd_clk;
always #15 wr_clk = ~wr_clk;

async_fifo_top UUT (
    .wr_clk_i   (wr_clk),
    .rd_clk_i   (rd_clk),
    .rst_n_i    (rst_n),
    .wr_en_i    (wr_en),
    .wr_data_i  (wr_data),
    .wr_full_o  (wr_full),
    .rd_en_i    (rd_en),
    .rd_data_o  (rd_data),
    .rd_valid_o (rd_valid),
    .rd_empty_o (rd_empty)
);

// write domain: model update and full flag rules
always @(posedge wr_clk) begin : wr_monitor
    int unstarted;
    if (rst_n) begin
        if (push_count == 0) begin
            assert (!wr_full) else begin
                wr_errors++;
                $display("Fail %s: wr_full_o expected 0 actual %0b", test_name, wr_full);
            end
        end
        // pops older than five write cycles have surely crossed
        if (wr_full) begin
            unstarted = LANES * (push_count - (pop_hist[4] + LANES - 1) / LANES);
            assert (unstarted >= `FIFO_RD_DEPTH - LANES) else begin
                wr_errors++;
                $display("Fail %s: unstarted bytes while full expected >= %0d actual %0d",
                         test_name, `FIFO_RD_DEPTH - LANES, unstarted);
            end
        end
        if (wr_en && !wr_full) begin
            for (int k = 0; k < LANES; k++) begin
                model_q.push_back(wr_data[k*`FIFO_RD_WIDTH +: `FIFO_RD_WIDTH]);
            end
            push_count++;
        end
    end
    for (int i = 4; i > 0; i--) begin
        pop_hist[i] = pop_hist[i-1];
    end
    pop_hist[0] = pop_count;
end

// read domain: valid timing, byte order and empty flag
always @(posedge rd_clk) begin : rd_checker
    rd_byte_t expected;
    if (rst_n) begin
        assert (rd_valid == pop_prev) else begin
            rd_errors++;
            $display("Fail %s: rd_valid_o expected %0b actual %0b",
                     test_name, pop_prev, rd_valid);
        end
        if (rd_valid) begin
            assert (model_q.size() > 0) else begin
                rd_errors++;
                $display("underflow in %s: a byte came out that was never pushed", test_name);
            end
            if (model_q.size() > 0) begin
                expected = model_q.pop_front();
                assert (rd_data == expected) else begin
                    rd_errors++;
                    $display("Fail %s: rd_data_o expected %02h actual %02h",
                             test_name, expected, rd_data);
                end
                rx_count++;
            end
        end
        if (push_count == 0) begin
            assert (rd_empty) else begin
                rd_errors++;
                $display("Fail %s: rd_empty_o expected 1 actual %0b", test_name, rd_empty);
            end
        end
        pop_prev = rd_en && !rd_empty;
        if (pop_prev) begin
            pop_count++;
        end
    end else begin
        pop_prev = 1'b0;
    end
end

// run limit in read cycles
always @(posedge rd_clk) begin : run_limit
    cycle_count = cycle_count + 1;
    if (cycle_count == CYCLE_LIMIT) begin
        $display("timeout: the run did not finish within %0d read cycles", CYCLE_LIMIT);
        $display("errors: write %0d read %0d sequence %0d", wr_errors, rd_errors, seq_errors);
        $display("STATUS: FAIL");
        $finish;
    end
end

task automatic push_word(input wr_word_t data);
    @(posedge wr_clk);
    wr_en   <= 1'b1;
    wr_data <= data;
endtask

task automatic wr_idle();
    @(posedge wr_clk);
    wr_en <= 1'b0;
endtask

task automatic pop_bytes(input int n);
    repeat (n) begin
        @(posedge rd_clk);
        rd_en <= 1'b1;
    end
    @(posedge rd_clk);
    rd_en <= 1'b0;
endtask

// pop until the FIFO has stayed empty with no byte in flight for a while
task automatic drain_fifo();
    int idle;
    idle = 0;
    @(posedge rd_clk);
    rd_en <= 1'b1;
    while (idle < IDLE_CYCLES) begin
        @(negedge rd_clk);
        if (rd_empty && !rd_valid) begin
            idle++;
        end else begin
            idle = 0;
        end
    end
    @(posedge rd_clk);
    rd_en <= 1'b0;
endtask

// enough write cycles for the read pointer to cross over
task automatic settle_crossing();
    repeat (8) @(posedge wr_clk);
endtask

task automatic check_flag(input string what, input logic expected, input logic actual);
    assert (actual === expected) else begin
        seq_errors++;
        $display("Fail %s: %s expected %0b actual %0b", test_name, what, expected, actual);
    end
endtask

task automatic check_count(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
        seq_errors++;
        $display("Fail %s: %s expected %0d actual %0d", test_name, what, expected, actual);
    end
endtask

initial begin : main_seq
    void'($urandom(32'ha06));
    rst_n   <= 1'b0;
    wr_en   <= 1'b0;
    wr_data <= '0;
    rd_en   <= 1'b0;
    random_done = 1'b0;

    // hold reset for at least five cycles of each clock
    repeat (5) @(posedge wr_clk);
    @(posedge rd_clk);
    rst_n <= 1'b1;

    test_name = "reset";
    repeat (5) @(negedge rd_clk);
    check_flag("rd_empty_o", 1'b1, rd_empty);
    check_flag("rd_valid_o", 1'b0, rd_valid);
    @(negedge wr_clk);
    check_flag("wr_full_o", 1'b0, wr_full);

    // one word comes out as four bytes, lowest lane first
    test_name = "unpack";
    rx_start = rx_count;
    push_word(32'h44332211);
    wr_idle();
    @(negedge rd_clk);
    while (rd_empty) begin
        @(negedge rd_clk);
    end
    pop_bytes(LANES);
    repeat (3) @(negedge rd_clk);
    check_flag("rd_empty_o", 1'b1, rd_empty);
    check_count("bytes received", LANES, rx_count - rx_start);
    settle_crossing();

    // overfill, the extra words must vanish
    test_name = "full_drop";
    rx_start = rx_count;
    push_start = push_count;
    repeat (`FIFO_WR_DEPTH + 4) push_word($urandom);
    wr_idle();
    @(negedge wr_clk);
    check_flag("wr_full_o", 1'b1, wr_full);
    check_count("words accepted", `FIFO_WR_DEPTH, push_count - push_start);
    drain_fifo();
    check_count("bytes received", `FIFO_RD_DEPTH, rx_count - rx_start);
    settle_crossing();

    // pops into an empty FIFO, then data arrives under the same strobe
    test_name = "empty_ignore";
    rx_start = rx_count;
    @(posedge rd_clk);
    rd_en <= 1'b1;
    repeat (10) @(posedge rd_clk);
    push_word($urandom);
    push_word($urandom);
    wr_idle();
    drain_fifo();
    check_count("bytes received", 2 * LANES, rx_count - rx_start);
    settle_crossing();

    test_name = "random";
    rx_start = rx_count;
    push_start = push_count;
    fork
        begin : wr_traffic
            while (!random_done) begin
                @(posedge wr_clk);
                wr_en   <= ($urandom % 4 == 0);
                wr_data <= $urandom;
            end
        end
        begin : rd_traffic
            for (int i = 0; i < RANDOM_CYCLES; i++) begin
                @(posedge rd_clk);
                // slow and fast read phases push the FIFO to full and back to empty
                if ((i / 250) % 2 == 0) begin
                    rd_en <= ($urandom % 4 == 0);
                end else begin
                    rd_en <= ($urandom % 10 != 0);
                end
            end
            random_done = 1'b1;
        end
    join
    wr_idle();
    drain_fifo();
    check_count("bytes received", LANES * (push_count - push_start), rx_count - rx_start);

    $display("errors: write %0d read %0d sequence %0d", wr_errors, rd_errors, seq_errors);
    if (wr_errors + rd_errors + seq_errors == 0) begin
        $display("STATUS: PASS");
    end else begin
        $display("STATUS: FAIL");
    end
    $finish;
end

endmodule
